//--- hdl/fir_types_pkg.sv
`default_nettype none

package fir_types_pkg;

    // ========================================================================
    // Datapath widths
    // ========================================================================
    localparam int SAMPLE_W  = 16;
    localparam int COEF_W    = 16;
    localparam int PREADD_W  = SAMPLE_W + 1;           // Sum of two samples
    localparam int PRODUCT_W = SAMPLE_W + COEF_W + 1;
    localparam int ACC_W     = PRODUCT_W + 4;          // Guard bits for up to 16 taps

    // ========================================================================
    // Datapath types
    // ========================================================================
    typedef logic signed [SAMPLE_W-1:0]  sample_t;
    typedef logic signed [COEF_W-1:0]    coef_t;
    typedef logic signed [PREADD_W-1:0]  preadd_t;
    typedef logic signed [PRODUCT_W-1:0] product_t;
    typedef logic signed [ACC_W-1:0]     acc_t;

    typedef struct packed {
        sample_t y;
        logic    sat;  // Set when y was clipped
    } fir_result_t;

endpackage

`default_nettype wire

//--- hdl/fir_coef_pkg.sv
`default_nettype none

package fir_coef_pkg;

    localparam int MAX_TAPS    = 8;
    localparam int DEF_TAP_NUM = 4;

    // Half of the symmetric impulse response, outermost tap first
    localparam fir_types_pkg::coef_t COEF_SET [MAX_TAPS] = '{
        16'sd1205,
        -16'sd2311,
        16'sd4790,
        16'sd13870,
        16'sd20310,
        -16'sd3017,
        16'sd837,
        -16'sd296
    };

endpackage

`default_nettype wire

//--- hdl/sample_delay_line.sv
`default_nettype none

module sample_delay_line #(
    parameter int DELAY = 8
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  en_i,
    input  fir_types_pkg::sample_t data_i,
    output fir_types_pkg::sample_t data_o
);

    fir_types_pkg::sample_t dly_q [DELAY];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < DELAY; i++) begin
                dly_q[i] <= '0;
            end
        end else if (en_i) begin
            dly_q[0] <= data_i;
            for (int i = 1; i < DELAY; i++) begin
                dly_q[i] <= dly_q[i-1];  // Shift one sample per strobe
            end
        end
    end

    assign data_o = dly_q[DELAY-1];

    // ========================================================================
    // Checks
    // ========================================================================
    // Tail feeds every element, so an X here spreads to the whole sum
    a_data_known : assert property (
        @(posedge clk_i) disable iff (rst_i)
        !$isunknown(data_o)
    ) else $error("delay line output is unknown after reset");

endmodule

`default_nettype wire

//--- hdl/sym_systolic_element.sv
`default_nettype none

module sym_systolic_element (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   en_i,
    input  fir_types_pkg::coef_t   coef_i,
    input  fir_types_pkg::sample_t head_i,
    input  fir_types_pkg::sample_t tail_i,
    input  fir_types_pkg::acc_t    casc_i,
    output fir_types_pkg::sample_t head_o,
    output fir_types_pkg::acc_t    casc_o
);

    // Largest pre-add two legal samples can produce
    localparam fir_types_pkg::preadd_t PREADD_MAX =
        (fir_types_pkg::preadd_t'(1) <<< fir_types_pkg::SAMPLE_W) - fir_types_pkg::preadd_t'(2);

    fir_types_pkg::sample_t  head_q1;
    fir_types_pkg::sample_t  head_q2;
    fir_types_pkg::preadd_t  preadd_q;
    fir_types_pkg::product_t prod_q;
    fir_types_pkg::acc_t     casc_q;

    // ========================================================================
    // Systolic head path, two steps per tap
    // ========================================================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            head_q1 <= '0;
            head_q2 <= '0;
        end else if (en_i) begin
            head_q1 <= head_i;
            head_q2 <= head_q1;
        end
    end

    assign head_o = head_q2;

    // ========================================================================
    // Pre-add, multiply and cascade sum
    // ========================================================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            preadd_q <= '0;
            prod_q   <= '0;
            casc_q   <= '0;
        end else if (en_i) begin
            preadd_q <= fir_types_pkg::preadd_t'(head_q1)
                      + fir_types_pkg::preadd_t'(tail_i);  // Mirror pair sum
            prod_q   <= fir_types_pkg::product_t'(preadd_q)
                      * fir_types_pkg::product_t'(coef_i);
            casc_q   <= fir_types_pkg::acc_t'(prod_q) + casc_i;
        end
    end

    assign casc_o = casc_q;

    // ========================================================================
    // Checks
    // ========================================================================
    // Pre-add must stay inside the pair range, one bit above sample width
    a_preadd_range : assert property (
        @(posedge clk_i) disable iff (rst_i)
        preadd_q <= PREADD_MAX
    ) else $error("pre-add %0d exceeds the sample pair range", preadd_q);

endmodule

`default_nettype wire

//--- hdl/sym_systolic_fir.sv
`default_nettype none

module sym_systolic_fir #(
    parameter int TAP_NUM = fir_coef_pkg::DEF_TAP_NUM
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   en_i,
    input  fir_types_pkg::sample_t data_i,
    output fir_types_pkg::acc_t    acc_o,
    output logic                   acc_valid_o
);

    // Tail must reach each element together with its mirrored head sample
    localparam int TAIL_DELAY = 2 * TAP_NUM;

    fir_types_pkg::sample_t tail_w;
    fir_types_pkg::sample_t head_w [TAP_NUM];
    fir_types_pkg::acc_t    casc_w [TAP_NUM+1];

    // ========================================================================
    // Elaboration check
    // ========================================================================
    if (TAP_NUM < 1 || TAP_NUM > fir_coef_pkg::MAX_TAPS) begin : g_tap_check
        $error("TAP_NUM %0d outside 1..%0d", TAP_NUM, fir_coef_pkg::MAX_TAPS);
    end

    assign head_w[0] = data_i;
    assign casc_w[0] = '0;  // Chain starts from an empty sum

    sample_delay_line #(
        .DELAY(TAIL_DELAY)
    ) i_tail_delay (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .en_i  (en_i),
        .data_i(data_i),
        .data_o(tail_w)
    );

    // ========================================================================
    // Systolic chain
    // ========================================================================
    for (genvar i = 0; i < TAP_NUM; i++) begin : g_tap
        if (i < TAP_NUM - 1) begin : g_mid
            sym_systolic_element i_element (
                .clk_i (clk_i),
                .rst_i (rst_i),
                .en_i  (en_i),
                .coef_i(fir_coef_pkg::COEF_SET[i]),
                .head_i(head_w[i]),
                .tail_i(tail_w),
                .casc_i(casc_w[i]),
                .head_o(head_w[i+1]),
                .casc_o(casc_w[i+1])
            );
        end else begin : g_last
            sym_systolic_element i_element (
                .clk_i (clk_i),
                .rst_i (rst_i),
                .en_i  (en_i),
                .coef_i(fir_coef_pkg::COEF_SET[i]),
                .head_i(head_w[i]),
                .tail_i(tail_w),
                .casc_i(casc_w[i]),
                .head_o(),            // Head path ends here
                .casc_o(casc_w[i+1])
            );
        end
    end

    assign acc_o = casc_w[TAP_NUM];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            acc_valid_o <= 1'b0;
        end else begin
            acc_valid_o <= en_i;  // One clock behind the strobe
        end
    end

endmodule

`default_nettype wire

//--- hdl/output_scaler.sv
`default_nettype none

module output_scaler #(
    parameter int OUT_SHIFT = fir_types_pkg::COEF_W - 1
) (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  fir_types_pkg::acc_t        acc_i,
    input  logic                       acc_valid_i,
    output fir_types_pkg::fir_result_t result_o,
    output logic                       valid_o
);

    localparam int WIDE_W = fir_types_pkg::ACC_W + 1;  // Room for the rounding carry

    typedef logic signed [WIDE_W-1:0] wide_t;

    localparam wide_t ROUND_C = wide_t'(1) <<< (OUT_SHIFT - 1);
    localparam wide_t Y_MAX   = (wide_t'(1) <<< (fir_types_pkg::SAMPLE_W - 1)) - wide_t'(1);
    localparam wide_t Y_MIN   = -(wide_t'(1) <<< (fir_types_pkg::SAMPLE_W - 1));

    wide_t                      rounded;
    wide_t                      shifted;
    fir_types_pkg::fir_result_t scaled;

    if (OUT_SHIFT < 1 || OUT_SHIFT >= WIDE_W) begin : g_shift_check
        $error("OUT_SHIFT %0d outside 1..%0d", OUT_SHIFT, WIDE_W - 1);
    end

    // ========================================================================
    // Round, shift and clip
    // ========================================================================
    always_comb begin
        rounded = wide_t'(acc_i) + ROUND_C;
        shifted = rounded >>> OUT_SHIFT;
        if (shifted > Y_MAX) begin
            scaled.y   = fir_types_pkg::sample_t'(Y_MAX);
            scaled.sat = 1'b1;
        end else if (shifted < Y_MIN) begin
            scaled.y   = fir_types_pkg::sample_t'(Y_MIN);
            scaled.sat = 1'b1;
        end else begin
            scaled.y   = fir_types_pkg::sample_t'(shifted);
            scaled.sat = 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            result_o <= '0;
            valid_o  <= 1'b0;
        end else begin
            valid_o <= acc_valid_i;
            if (acc_valid_i) begin
                result_o <= scaled;  // Held until the next strobe
            end
        end
    end

    // ========================================================================
    // Checks
    // ========================================================================
    a_sat_at_limit : assert property (
        @(posedge clk_i) disable iff (rst_i)
        result_o.sat |-> (result_o.y == fir_types_pkg::sample_t'(Y_MAX)
                       || result_o.y == fir_types_pkg::sample_t'(Y_MIN))
    ) else $error("sat set with y = %0d, not at a limit", result_o.y);

endmodule

`default_nettype wire

//--- hdl/fir_filter_top.sv
`default_nettype none

module fir_filter_top #(
    parameter int TAP_NUM   = fir_coef_pkg::DEF_TAP_NUM,
    parameter int OUT_SHIFT = fir_types_pkg::COEF_W - 1
) (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       en_i,
    input  fir_types_pkg::sample_t     data_i,
    output fir_types_pkg::fir_result_t result_o,
    output logic                       valid_o
);

    fir_types_pkg::acc_t acc_w;
    logic                acc_valid_w;

    sym_systolic_fir #(
        .TAP_NUM(TAP_NUM)
    ) i_core (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .en_i       (en_i),
        .data_i     (data_i),
        .acc_o      (acc_w),
        .acc_valid_o(acc_valid_w)
    );

    output_scaler #(
        .OUT_SHIFT(OUT_SHIFT)
    ) i_scaler (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .acc_i      (acc_w),
        .acc_valid_i(acc_valid_w),
        .result_o   (result_o),
        .valid_o    (valid_o)
    );

endmodule

`default_nettype wire

//--- verification/fir_checker.sv
`default_nettype none

module fir_checker #(
    parameter int TAP_NUM   = fir_coef_pkg::DEF_TAP_NUM,
    parameter int OUT_SHIFT = fir_types_pkg::COEF_W - 1
) (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       en_i,
    input  fir_types_pkg::sample_t     data_i,
    input  fir_types_pkg::fir_result_t result_i,
    input  logic                       valid_i,
    output int                         value_errs_o,
    output int                         timing_errs_o,
    output int                         checked_o,
    output int                         sat_seen_o,
    output int                         pending_o
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int     LATENCY = TAP_NUM + 2;  // In accepted samples
    localparam longint Y_MAX   = (longint'(1) <<< (fir_types_pkg::SAMPLE_W - 1)) - 1;
    localparam longint Y_MIN   = -(longint'(1) <<< (fir_types_pkg::SAMPLE_W - 1));

    fir_types_pkg::sample_t     hist [$];   // Accepted samples since reset
    fir_types_pkg::fir_result_t exp_q [$];  // Results still owed by the DUT
    logic [1:0]                 en_hist = '0;
    logic                       rst_q   = 1'b0;
    logic                       armed   = 1'b0;
    int                         value_errs  = 0;
    int                         timing_errs = 0;
    int                         checked     = 0;
    int                         sat_seen    = 0;
    int                         pending     = 0;

    assign value_errs_o  = value_errs;
    assign timing_errs_o = timing_errs;
    assign checked_o     = checked;
    assign sat_seen_o    = sat_seen;
    assign pending_o     = pending;

    // ========================================================================
    // Reference model
    // ========================================================================
    function automatic longint sample_at(input int idx);
        if (idx < 0 || idx >= hist.size()) begin
            return 0;  // Zero before the first sample
        end
        return longint'(hist[idx]);
    endfunction

    // Direct form of the even-symmetric sum for output index n
    function automatic longint filter_sum(input int n);
        longint acc;
        acc = 0;
        for (int k = 0; k < TAP_NUM; k++) begin
            acc += longint'(fir_coef_pkg::COEF_SET[k])
                 * (sample_at(n - k) + sample_at(n - (2 * TAP_NUM - 1 - k)));
        end
        return acc;
    endfunction

    function automatic fir_types_pkg::fir_result_t scale(input longint acc);
        longint                     shifted;
        fir_types_pkg::fir_result_t r;
        shifted = (acc + (longint'(1) <<< (OUT_SHIFT - 1))) >>> OUT_SHIFT;
        r.sat   = (shifted > Y_MAX) || (shifted < Y_MIN);
        if (shifted > Y_MAX) begin
            r.y = fir_types_pkg::sample_t'(Y_MAX);
        end else if (shifted < Y_MIN) begin
            r.y = fir_types_pkg::sample_t'(Y_MIN);
        end else begin
            r.y = fir_types_pkg::sample_t'(shifted);
        end
        return r;
    endfunction

    // ========================================================================
    // Monitor and compare
    // ========================================================================
    always @(posedge clk_i) begin
        fir_types_pkg::fir_result_t exp_r;
        if (rst_i) begin
            hist.delete();
            exp_q.delete();
            en_hist = '0;
            rst_q   = 1'b1;
            armed   = 1'b1;
            pending = 0;
        end else if (armed) begin
            if (rst_q) begin  // First edge after reset sees the cleared outputs
                if (valid_i !== 1'b0) begin
                    $display("mismatch at %0t: valid_o expected 0, got %0b", $time, valid_i);
                    value_errs++;
                end
                if (result_i !== '0) begin
                    $display("mismatch at %0t: result_o expected 0, got %0h", $time, result_i);
                    value_errs++;
                end
            end
            if (valid_i === 1'b1 && en_hist[1]) begin
                exp_r = exp_q.pop_front();
                if (result_i.y !== exp_r.y) begin
                    $display("mismatch at %0t: result_o.y expected %0d, got %0d",
                             $time, exp_r.y, result_i.y);
                    value_errs++;
                end
                if (result_i.sat !== exp_r.sat) begin
                    $display("mismatch at %0t: result_o.sat expected %0b, got %0b",
                             $time, exp_r.sat, result_i.sat);
                    value_errs++;
                end
                if (result_i.sat === 1'b1) begin
                    sat_seen++;
                end
                checked++;
            end else if (valid_i !== 1'b0 && !en_hist[1]) begin
                $display("valid_o pulse at %0t with no enable two clocks earlier", $time);
                timing_errs++;
            end else if (en_hist[1]) begin
                $display("no valid_o pulse at %0t two clocks after an enable", $time);
                timing_errs++;
                exp_r = exp_q.pop_front();  // Keep later results aligned
            end
            en_hist = {en_hist[0], en_i};
            if (en_i) begin
                hist.push_back(data_i);
                exp_q.push_back(scale(filter_sum(hist.size() - 1 - LATENCY)));
            end
            rst_q   = 1'b0;
            pending = exp_q.size();
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_fir_filter_top.sv
`default_nettype none

module tb_fir_filter_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TAP_NUM   = fir_coef_pkg::DEF_TAP_NUM;
    localparam int OUT_SHIFT = fir_types_pkg::COEF_W - 1;

    localparam fir_types_pkg::sample_t S_MAX = {1'b0, {(fir_types_pkg::SAMPLE_W - 1){1'b1}}};
    localparam fir_types_pkg::sample_t S_MIN = {1'b1, {(fir_types_pkg::SAMPLE_W - 1){1'b0}}};

    // ========================================================================
    // Test lengths in clock cycles
    // ========================================================================
    localparam int RESET_CYCLES   = 8;
    localparam int IMPULSE_LEN    = 40;
    localparam int RANDOM_LEN     = 800;
    localparam int GAP_LEN        = 1000;
    localparam int SAT_RUN        = 60;
    localparam int PRE_RST_LEN    = 200;
    localparam int MID_RST_CYCLES = 4;
    localparam int POST_RST_LEN   = 260;
    localparam int DRAIN_ALLOW    = 6 * 4;  // Six drains of a few clocks each
    localparam int TEST_CYCLES    = RESET_CYCLES + IMPULSE_LEN + RANDOM_LEN + GAP_LEN
                                  + 3 * SAT_RUN + PRE_RST_LEN + MID_RST_CYCLES
                                  + POST_RST_LEN + DRAIN_ALLOW;
    localparam int MAX_CYCLES     = 2 * TEST_CYCLES + 1000;

    logic                       clk  = 1'b0;
    logic                       rst;
    logic                       en;
    fir_types_pkg::sample_t     data;
    fir_types_pkg::fir_result_t result;
    logic                       valid;

    int seed;
    int cycle_cnt = 0;
    int tb_errs   = 0;
    int value_errs;
    int timing_errs;
    int checked;
    int sat_seen;
    int pending;

    always #10 clk = ~clk;

    fir_filter_top #(
        .TAP_NUM  (TAP_NUM),
        .OUT_SHIFT(OUT_SHIFT)
    ) i_dut (
        .clk_i   (clk),
        .rst_i   (rst),
        .en_i    (en),
        .data_i  (data),
        .result_o(result),
        .valid_o (valid)
    );

    fir_checker #(
        .TAP_NUM  (TAP_NUM),
        .OUT_SHIFT(OUT_SHIFT)
    ) i_checker (
        .clk_i        (clk),
        .rst_i        (rst),
        .en_i         (en),
        .data_i       (data),
        .result_i     (result),
        .valid_i      (valid),
        .value_errs_o (value_errs),
        .timing_errs_o(timing_errs),
        .checked_o    (checked),
        .sat_seen_o   (sat_seen),
        .pending_o    (pending)
    );

    // ========================================================================
    // Stimulus tasks
    // ========================================================================
    task automatic send_impulse();
        for (int i = 0; i < IMPULSE_LEN; i++) begin
            @(posedge clk);
            en   <= 1'b1;
            data <= (i == 0) ? S_MAX : '0;
        end
    endtask

    task automatic send_random(input int len, input logic gaps);
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            en   <= gaps ? 1'($random(seed)) : 1'b1;  // About half enabled with gaps
            data <= fir_types_pkg::sample_t'($random(seed));
        end
    endtask

    task automatic send_level(input int len, input fir_types_pkg::sample_t level);
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            en   <= 1'b1;
            data <= level;
        end
    endtask

    task automatic send_moderate(input int len);
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            en   <= 1'b1;
            data <= fir_types_pkg::sample_t'($random(seed) % 1024);
        end
    endtask

    task automatic apply_reset(input int cycles);
        @(posedge clk);
        rst <= 1'b1;
        repeat (cycles - 1) begin
            @(posedge clk);
            en   <= 1'($random(seed));  // Ignored while in reset
            data <= fir_types_pkg::sample_t'($random(seed));
        end
        @(posedge clk);
        rst <= 1'b0;
    endtask

    // Stop the strobe and wait for every owed result
    task automatic drain_results();
        @(posedge clk);
        en <= 1'b0;
        @(negedge clk);
        while (pending != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic check_saturation();
        int sat_before;
        sat_before = sat_seen;
        send_level(SAT_RUN, S_MAX);
        send_level(SAT_RUN, S_MIN);
        drain_results();
        if (sat_seen - sat_before < SAT_RUN) begin
            $display("saturation flag set on only %0d results during full-scale runs",
                     sat_seen - sat_before);
            tb_errs++;
        end
        send_moderate(SAT_RUN);
        drain_results();
    endtask

    task automatic report_counts();
        $display("errors: %0d value, %0d timing, %0d other; %0d results checked",
                 value_errs, timing_errs, tb_errs, checked);
    endtask

    // ========================================================================
    // Test sequence and timeout
    // ========================================================================
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout after %0d cycles with %0d results outstanding",
                     cycle_cnt, pending);
            report_counts();
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        seed = 32'h6467b559;
        rst  = 1'b1;
        en   = 1'b0;
        data = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        send_impulse();
        drain_results();
        send_random(RANDOM_LEN, 1'b0);
        drain_results();
        send_random(GAP_LEN, 1'b1);
        drain_results();
        check_saturation();
        send_random(PRE_RST_LEN, 1'b1);
        apply_reset(MID_RST_CYCLES);
        send_random(POST_RST_LEN, 1'b1);
        drain_results();

        if (checked == 0) begin
            $display("no results were compared");
            tb_errs++;
        end
        report_counts();
        if (value_errs + timing_errs + tb_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- fir_filter_top.f
hdl/fir_types_pkg.sv
hdl/fir_coef_pkg.sv
hdl/sample_delay_line.sv
hdl/sym_systolic_element.sv
hdl/sym_systolic_fir.sv
hdl/output_scaler.sv
hdl/fir_filter_top.sv
verification/fir_checker.sv
verification/tb_fir_filter_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the FIR filter testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_fir_filter_top
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module "$TOP" -Mdir obj_dir -f fir_filter_top.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The testbench prints its verdict on a line of its own
if grep -qx "Test OK" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed, see $LOG"
exit 1
